// ==== design/mult_config.svh ====
// sizes shared by the multiplier stages and the testbench; include wherever a width is needed.
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// width of each unsigned operand.
`define MULT_OPERAND_WIDTH 16

// full double-width result, so no product bit is lost.
`define MULT_PRODUCT_WIDTH (2 * `MULT_OPERAND_WIDTH)

// register stages from operands to product.
// partial products, carry-save tree, prefix adder.
`define MULT_PIPE_DEPTH 3

`endif

// ==== design/mult_pkg.sv ====
// data types passed between the multiplier pipeline stages; imported by each stage.
`default_nettype none

`include "mult_config.svh"

package mult_pkg;

  // one unsigned operand.
  typedef logic [`MULT_OPERAND_WIDTH-1:0] operand_t;

  // a product, or any row already at product width.
  typedef logic [`MULT_PRODUCT_WIDTH-1:0] product_t;

  // one row per operand bit, each shifted to its weight.
  typedef product_t [`MULT_OPERAND_WIDTH-1:0] pp_array_t;

endpackage : mult_pkg

`default_nettype wire

// ==== design/partial_product_gen.sv ====
// first multiplier stage: builds the AND array of shifted partial products and registers it.
`timescale 1ns/10ps
`default_nettype none

`include "mult_config.svh"

module partial_product_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  mult_pkg::operand_t  x,
  input  mult_pkg::operand_t  y,
  output logic                pp_valid,
  output mult_pkg::pp_array_t pp_rows
);
  import mult_pkg::*;

  pp_array_t rows_next;

  // row i is y gated by x[i], moved up to weight 2**i.
  always_comb begin
    for (int i = 0; i < `MULT_OPERAND_WIDTH; i++) begin
      rows_next[i] = product_t'({`MULT_OPERAND_WIDTH{x[i]}} & y) << i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  // rows hold their value while no new pair arrives.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pp_rows <= rows_next;
    end
  end

  a_operands_known: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown({x, y}));

endmodule : partial_product_gen

`default_nettype wire

// ==== design/csa_reduction_tree.sv ====
// second multiplier stage: carry-save tree that squeezes the partial products into two rows.
`timescale 1ns/10ps
`default_nettype none

`include "mult_config.svh"

module csa_reduction_tree (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pp_valid,
  input  mult_pkg::pp_array_t pp_rows,
  output logic                csa_valid,
  output mult_pkg::product_t  sum_row,
  output mult_pkg::product_t  carry_row
);
  import mult_pkg::*;

  localparam int W    = `MULT_PRODUCT_WIDTH;
  localparam int ROWS = `MULT_OPERAND_WIDTH;

  // each group of three rows becomes two, leftovers pass down.
  function automatic int rows_after(input int n);
    return (n / 3) * 2 + n % 3;
  endfunction

  function automatic int rows_at_level(input int lvl);
    int rows;
    rows = ROWS;
    for (int i = 0; i < lvl; i++) begin
      rows = rows_after(rows);
    end
    return rows;
  endfunction

  function automatic int tree_levels(input int n);
    int rows;
    int levels;
    rows = n;
    levels = 0;
    for (int i = 0; i < n; i++) begin
      if (rows > 2) begin
        rows = rows_after(rows);
        levels++;
      end
    end
    return levels;
  endfunction

  // 16 rows go 11, 8, 6, 4, 3, 2.
  localparam int LEVELS = tree_levels(ROWS);

  product_t tree [LEVELS+1][ROWS];

  for (genvar r = 0; r < ROWS; r++) begin : g_load
    assign tree[0][r] = pp_rows[r];
  end

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int N_IN   = rows_at_level(l);
    localparam int GROUPS = N_IN / 3;
    localparam int N_OUT  = rows_after(N_IN);

    // full adder per column, made of two half adders and an or.
    for (genvar k = 0; k < GROUPS; k++) begin : g_csa
      product_t ha_sum;
      product_t ha_carry;
      product_t fa_carry;

      assign ha_sum   = tree[l][3*k] ^ tree[l][3*k+1];
      assign ha_carry = tree[l][3*k] & tree[l][3*k+1];
      assign fa_carry = ha_carry | (ha_sum & tree[l][3*k+2]);

      assign tree[l+1][2*k]   = ha_sum ^ tree[l][3*k+2];
      // carries move one column up; bit 32 is always zero here.
      assign tree[l+1][2*k+1] = {fa_carry[W-2:0], 1'b0};
    end

    for (genvar k = 3 * GROUPS; k < N_IN; k++) begin : g_pass
      assign tree[l+1][k-GROUPS] = tree[l][k];
    end

    for (genvar k = N_OUT; k < ROWS; k++) begin : g_unused
      assign tree[l+1][k] = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      csa_valid <= 1'b0;
    end else begin
      csa_valid <= pp_valid;
    end
  end

  // last level is a single compressor: sum in row 0, carry in row 1.
  always_ff @(posedge clk) begin
    if (pp_valid) begin
      sum_row   <= tree[LEVELS][0];
      carry_row <= tree[LEVELS][1];
    end
  end

  a_carry_lsb_zero: assert property (@(posedge clk) disable iff (!rst_n)
    csa_valid |-> !carry_row[0]);

endmodule : csa_reduction_tree

`default_nettype wire

// ==== design/prefix_adder.sv ====
// third multiplier stage: parallel-prefix adder of the sum and carry rows, registers the product.
`timescale 1ns/10ps
`default_nettype none

`include "mult_config.svh"

module prefix_adder (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               csa_valid,
  input  mult_pkg::product_t sum_row,
  input  mult_pkg::product_t carry_row,
  output logic               out_valid,
  output mult_pkg::product_t product
);
  import mult_pkg::*;

  localparam int W      = `MULT_PRODUCT_WIDTH;
  localparam int LEVELS = $clog2(W);

  // group generate and propagate after each prefix level.
  product_t gen  [LEVELS+1];
  product_t prop [LEVELS];
  product_t sum_next;
  logic     carry_out;

  assign gen[0]  = sum_row & carry_row;
  assign prop[0] = sum_row ^ carry_row;

  // kogge-stone style, span doubles every level.
  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int D = 1 << l;

    for (genvar i = 0; i < W; i++) begin : g_bit
      if (i < D) begin : g_done
        // group already reaches bit 0.
        assign gen[l+1][i] = gen[l][i];
      end else if (i < 2 * D) begin : g_grey
        // grey cell, closes the group down to bit 0.
        assign gen[l+1][i] = gen[l][i] | (prop[l][i] & gen[l][i-D]);
      end else begin : g_black
        assign gen[l+1][i]  = gen[l][i] | (prop[l][i] & gen[l][i-D]);
        assign prop[l+1][i] = prop[l][i] & prop[l][i-D];
      end

      if (i < 2 * D && l < LEVELS - 1) begin : g_prop_hold
        assign prop[l+1][i] = prop[l][i];
      end
    end
  end

  // gen[LEVELS][i] is the carry out of bit i.
  assign sum_next  = prop[0] ^ {gen[LEVELS][W-2:0], 1'b0};
  assign carry_out = gen[LEVELS][W-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= csa_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (csa_valid) begin
      product <= sum_next;
    end
  end

  // the two rows add up to the true product, which fits in W bits.
  a_no_carry_out: assert property (@(posedge clk) disable iff (!rst_n)
    csa_valid |-> !carry_out);

endmodule : prefix_adder

`default_nettype wire

// ==== design/tree_multiplier.sv ====
// top of the three-stage unsigned tree multiplier; one operand pair per cycle, 3 cycles latency.
`timescale 1ns/10ps
`default_nettype none

`include "mult_config.svh"

module tree_multiplier (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  mult_pkg::operand_t x,
  input  mult_pkg::operand_t y,
  output logic               out_valid,
  output mult_pkg::product_t product
);
  import mult_pkg::*;

  logic      pp_valid;
  pp_array_t pp_rows;
  logic      csa_valid;
  product_t  sum_row;
  product_t  carry_row;

  partial_product_gen u_pp_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .x        (x),
    .y        (y),
    .pp_valid (pp_valid),
    .pp_rows  (pp_rows)
  );

  csa_reduction_tree u_csa_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .pp_valid  (pp_valid),
    .pp_rows   (pp_rows),
    .csa_valid (csa_valid),
    .sum_row   (sum_row),
    .carry_row (carry_row)
  );

  prefix_adder u_prefix_add (
    .clk       (clk),
    .rst_n     (rst_n),
    .csa_valid (csa_valid),
    .sum_row   (sum_row),
    .carry_row (carry_row),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule : tree_multiplier

`default_nettype wire

// ==== tests/tb_tree_multiplier.sv ====
// testbench for the pipelined tree multiplier; compile with sources.f and run tb_tree_multiplier as top.
`timescale 1ns/10ps
`default_nettype none

`include "mult_config.svh"

module tb_tree_multiplier;
  import mult_pkg::*;

  localparam int DRAIN_LIMIT = 20;
  localparam int STREAM_PAIRS = 200;
  localparam int GAPPY_CYCLES = 300;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t x;
  operand_t y;
  logic     out_valid;
  product_t product;

  // expected results in issue order with the cycle each pair was presented.
  product_t exp_q [$];
  int       acc_q [$];
  operand_t x_q [$];
  operand_t y_q [$];

  int cycle;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int test_err_start;
  int max_in_flight;
  int in_flight;
  logic [`MULT_PIPE_DEPTH-1:0] in_hist;
  product_t exp_val;
  int       acc_cycle;
  operand_t exp_x;
  operand_t exp_y;

  tree_multiplier u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .x         (x),
    .y         (y),
    .out_valid (out_valid),
    .product   (product)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // in_valid as seen by the first stage with one bit per pipeline stage.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_hist <= '0;
    end else begin
      in_hist <= {in_hist[`MULT_PIPE_DEPTH-2:0], in_valid};
    end
  end

  function automatic product_t ref_product(input operand_t a, input operand_t b);
    return product_t'(a) * product_t'(b);
  endfunction

  // outputs are sampled on the falling edge halfway between updates.
  always @(negedge clk) begin
    if (rst_n) begin
      checks++;
      assert (out_valid === in_hist[`MULT_PIPE_DEPTH-1]) else begin
        $display("MISMATCH at %0t: out_valid is %b but in_valid %0d cycles earlier was %b",
                 $time, out_valid, `MULT_PIPE_DEPTH, in_hist[`MULT_PIPE_DEPTH-1]);
        errors++;
      end
      if (out_valid === 1'b1) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          $display("error at %0t: product %h came out with no pair left to match it",
                   $time, product);
          errors++;
        end
        if (exp_q.size() != 0) begin
          in_flight = exp_q.size() - (in_valid ? 1 : 0);
          if (in_flight > max_in_flight) begin
            max_in_flight = in_flight;
          end
          exp_val   = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          exp_x     = x_q.pop_front();
          exp_y     = y_q.pop_front();
          checks += 2;
          assert (product === exp_val) else begin
            $display("MISMATCH at %0t: %h * %h gave %h, expected %h",
                     $time, exp_x, exp_y, product, exp_val);
            errors++;
          end
          assert (cycle - acc_cycle == `MULT_PIPE_DEPTH) else begin
            $display("error at %0t: product of %h * %h came %0d cycles after its pair",
                     $time, exp_x, exp_y, cycle - acc_cycle);
            errors++;
          end
        end
      end
    end
  end

  // one cycle of stimulus driven just after the rising edge.
  task automatic drive_cycle(input logic v, input operand_t a, input operand_t b);
    @(posedge clk);
    #1;
    in_valid = v;
    x = a;
    y = b;
    if (v) begin
      exp_q.push_back(ref_product(a, b));
      acc_q.push_back(cycle);
      x_q.push_back(a);
      y_q.push_back(b);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    drive_cycle(1'b0, '0, '0);
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("error at %0t: timed out with %0d products never delivered",
               $time, exp_q.size());
      errors++;
      exp_q.delete();
      acc_q.delete();
      x_q.delete();
      y_q.delete();
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = errors - test_err_start;
    tests_run++;
    if (n == 0) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, n);
      tests_failed++;
    end
    test_err_start = errors;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    x = '0;
    y = '0;
    cycle = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    test_err_start = 0;
    max_in_flight = 0;
    void'($urandom(32'h492a02b9));

    // out_valid must stay low through reset and until the first pair comes out.
    repeat (4) begin
      @(posedge clk);
      #1;
      checks++;
      assert (out_valid === 1'b0) else begin
        $display("MISMATCH at %0t: out_valid is %b during reset", $time, out_valid);
        errors++;
      end
    end
    rst_n = 1'b1;
    repeat (6) drive_cycle(1'b0, '0, '0);
    drive_cycle(1'b1, 16'h1234, 16'h0056);
    wait_drain(DRAIN_LIMIT);
    finish_test("reset and first output");

    drive_cycle(1'b1, 16'h0000, 16'h0000);
    wait_drain(DRAIN_LIMIT);
    drive_cycle(1'b1, 16'h0000, 16'hffff);
    wait_drain(DRAIN_LIMIT);
    drive_cycle(1'b1, 16'h0001, 16'hffff);
    wait_drain(DRAIN_LIMIT);
    drive_cycle(1'b1, 16'hffff, 16'hffff);
    wait_drain(DRAIN_LIMIT);
    drive_cycle(1'b1, 16'hffff, 16'h0001);
    wait_drain(DRAIN_LIMIT);
    finish_test("corner pairs");

    // every row and then every column of the array.
    for (int i = 0; i < `MULT_OPERAND_WIDTH; i++) begin
      drive_cycle(1'b1, operand_t'(1) << i, 16'ha5c3);
    end
    for (int i = 0; i < `MULT_OPERAND_WIDTH; i++) begin
      drive_cycle(1'b1, 16'h5a3c, operand_t'(1) << i);
    end
    wait_drain(DRAIN_LIMIT);
    finish_test("walking ones");

    max_in_flight = 0;
    for (int i = 0; i < STREAM_PAIRS; i++) begin
      drive_cycle(1'b1, operand_t'($urandom), operand_t'($urandom));
    end
    wait_drain(DRAIN_LIMIT);
    checks++;
    assert (max_in_flight == `MULT_PIPE_DEPTH) else begin
      $display("error at %0t: at most %0d pairs were in flight during the stream",
               $time, max_in_flight);
      errors++;
    end
    finish_test("back-to-back stream");

    for (int i = 0; i < GAPPY_CYCLES; i++) begin
      drive_cycle(logic'($urandom % 2), operand_t'($urandom), operand_t'($urandom));
    end
    wait_drain(DRAIN_LIMIT);
    finish_test("random valid pattern");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_tree_multiplier

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/mult_pkg.sv
design/partial_product_gen.sv
design/csa_reduction_tree.sv
design/prefix_adder.sv
design/tree_multiplier.sv
tests/tb_tree_multiplier.sv
